/* source/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // pc and branch target width
    localparam int word_bits = 32;

    // instructions are word aligned
    // so table and btb indexing starts above the byte offset
    localparam int pc_lsb = 2;

    // pc or target address
    typedef logic [word_bits-1:0] word_t;

    // rv32i major opcodes as carried down the pipeline
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // default predictor sizing, passed down from the top level
    localparam int default_weight_bits      = 8;
    localparam int default_hist_len         = 12;
    localparam int default_table_index_bits = 5;
    localparam int default_btb_index_bits   = 5;

    // magnitude below which a correct prediction still trains
    localparam int default_train_threshold  = 37;

endpackage : bp_pkg

`default_nettype wire

/* source/perceptron_table.sv */
`default_nettype none
`timescale 1ns/1ps

module perceptron_table #(
    parameter int weight_bits      = 8,
    parameter int hist_len         = 12,
    parameter int table_index_bits = 5
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    // fetch side read
    input  wire bp_pkg::word_t          rd_pc,
    output logic [weight_bits-1:0]      rd_weights [hist_len+1],

    // resolve side read and write, same row
    input  wire bp_pkg::word_t          wr_pc,
    input  wire logic                   wr_en,
    input  wire logic [weight_bits-1:0] wr_weights [hist_len+1],
    output logic [weight_bits-1:0]      train_weights [hist_len+1]
);

    import bp_pkg::*;

    localparam int rows = 2 ** table_index_bits;

    // row select from the pc bits just above the byte offset
    logic [table_index_bits-1:0] rd_index;
    logic [table_index_bits-1:0] wr_index;

    // one perceptron per row
    // last entry of each row is the bias weight
    logic [weight_bits-1:0] weights [rows][hist_len+1];

    assign rd_index = rd_pc[pc_lsb +: table_index_bits];
    assign wr_index = wr_pc[pc_lsb +: table_index_bits];

    // fetch read, combinational
    always_comb begin
        for (int j = 0; j <= hist_len; j++) begin
            rd_weights[j] = weights[rd_index][j];
        end
    end

    // resolve read, feeds the trainer with the old row
    always_comb begin
        for (int j = 0; j <= hist_len; j++) begin
            train_weights[j] = weights[wr_index][j];
        end
    end

    // whole row written at once
    // reset brings every weight to zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < rows; r++) begin
                for (int j = 0; j <= hist_len; j++) begin
                    weights[r][j] <= '0;
                end
            end
        end else if (wr_en) begin
            for (int j = 0; j <= hist_len; j++) begin
                weights[wr_index][j] <= wr_weights[j];
            end
        end
    end

endmodule : perceptron_table

`default_nettype wire

/* source/perceptron_eval.sv */
`default_nettype none
`timescale 1ns/1ps

module perceptron_eval #(
    parameter int weight_bits = 8,
    parameter int hist_len    = 12
) (
    // row selected by the fetch pc
    input  wire logic [weight_bits-1:0] weights [hist_len+1],

    // global history, bit 0 is the newest outcome
    input  wire logic [hist_len-1:0]    history,

    // signed perceptron output and direction guess
    output logic [weight_bits-1:0]      y_out,
    output logic                        pred_taken
);

    // per weight contribution to the dot product
    logic [weight_bits-1:0] term [hist_len+1];

    // running sum over all terms
    logic [weight_bits-1:0] acc;

    // history bit 1 keeps the weight
    // history bit 0 uses the bitwise inverse as a cheap negation
    // (off by one from a true negate, same as the pipeline's predictor)
    always_comb begin
        for (int i = 0; i < hist_len; i++) begin
            if (history[i]) begin
                term[i] = weights[i];
            end else begin
                term[i] = ~weights[i];
            end
        end
        // bias has no history input
        term[hist_len] = weights[hist_len];
    end

    // sum wraps modulo 2**weight_bits
    always_comb begin
        acc = '0;
        for (int i = 0; i <= hist_len; i++) begin
            acc = acc + term[i];
        end
    end

    assign y_out = acc;

    // taken only for a strictly positive output
    // zero counts as not taken, so a cleared table predicts not taken
    assign pred_taken = ($signed(y_out) > 0);

endmodule : perceptron_eval

`default_nettype wire

/* source/perceptron_trainer.sv */
`default_nettype none
`timescale 1ns/1ps

module perceptron_trainer #(
    parameter int weight_bits     = 8,
    parameter int hist_len        = 12,
    parameter int train_threshold = 37
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   load,

    // resolved instruction from ex/mem
    input  wire bp_pkg::opcode_t        ex_opcode,
    input  wire logic                   ex_taken,
    input  wire bp_pkg::word_t          ex_target,

    // prediction carried down with the instruction
    input  wire logic                   ex_pred_taken,
    input  wire logic [weight_bits-1:0] ex_y_out,
    input  wire bp_pkg::word_t          ex_pred_target,

    // table row for ex_pc before the update
    input  wire logic [weight_bits-1:0] old_weights [hist_len+1],

    output logic [hist_len-1:0]         history,
    output logic                        table_wr_en,
    output logic [weight_bits-1:0]      new_weights [hist_len+1],
    output logic                        btb_wr_en,
    output logic                        redirect
);

    import bp_pkg::*;

    localparam logic [weight_bits-1:0] plus_one  = weight_bits'(1);
    localparam logic [weight_bits-1:0] minus_one = '1;

    logic                   is_branch;
    logic                   dir_wrong;
    logic                   target_wrong;
    logic [weight_bits-1:0] y_mag;
    logic                   low_conf;

    assign is_branch = (ex_opcode == op_br);

    // direction and target checks against the front end guess
    assign dir_wrong    = (ex_pred_taken != ex_taken);
    assign target_wrong = ex_taken && (ex_pred_target != ex_target);

    // |y|, the most negative value stays as its unsigned pattern
    assign y_mag    = ex_y_out[weight_bits-1] ? (~ex_y_out + plus_one) : ex_y_out;
    assign low_conf = (y_mag < train_threshold);

    // flush the front end on any wrong branch guess
    assign redirect = is_branch && (dir_wrong || target_wrong);

    // train on a miss or on a weak correct guess
    assign table_wr_en = load && is_branch && (dir_wrong || low_conf);

    // every resolved branch refreshes its btb entry
    assign btb_wr_en = load && is_branch;

    // agree with history bit moves the weight up, disagree moves it down
    // uses the history before this branch shifts in
    always_comb begin
        for (int i = 0; i < hist_len; i++) begin
            new_weights[i] = old_weights[i] + ((ex_taken == history[i]) ? plus_one : minus_one);
        end
        // bias follows the outcome alone
        new_weights[hist_len] = old_weights[hist_len] + (ex_taken ? plus_one : minus_one);
    end

    // global history, newest outcome at bit 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            history <= '0;
        end else if (load && is_branch) begin
            history <= {history[hist_len-2:0], ex_taken};
        end
    end

endmodule : perceptron_trainer

`default_nettype wire

/* source/branch_target_buffer.sv */
`default_nettype none
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int btb_index_bits = 5
) (
    input  wire logic          clk,
    input  wire logic          arst_n,

    // fetch lookup
    input  wire bp_pkg::word_t rd_pc,
    output logic               hit,
    output bp_pkg::word_t      target,

    // resolve write
    input  wire bp_pkg::word_t wr_pc,
    input  wire logic          wr_en,
    input  wire bp_pkg::word_t wr_target
);

    import bp_pkg::*;

    localparam int entries  = 2 ** btb_index_bits;
    localparam int tag_lsb  = pc_lsb + btb_index_bits;
    localparam int tag_bits = word_bits - tag_lsb;

    logic [btb_index_bits-1:0] rd_index;
    logic [btb_index_bits-1:0] wr_index;
    logic [tag_bits-1:0]       rd_tag;
    logic [tag_bits-1:0]       wr_tag;

    // entry storage
    logic                valid [entries];
    logic [tag_bits-1:0] tags [entries];
    word_t               targets [entries];

    // index above the byte offset, tag is everything above the index
    assign rd_index = rd_pc[pc_lsb +: btb_index_bits];
    assign wr_index = wr_pc[pc_lsb +: btb_index_bits];
    assign rd_tag   = rd_pc[word_bits-1:tag_lsb];
    assign wr_tag   = wr_pc[word_bits-1:tag_lsb];

    // combinational lookup
    assign hit    = valid[rd_index] && (tags[rd_index] == rd_tag);
    assign target = targets[rd_index];

    // only the valid bits need clearing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int e = 0; e < entries; e++) begin
                valid[e] <= 1'b0;
            end
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // direct mapped, a conflicting pc simply replaces the entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_index]    <= wr_tag;
            targets[wr_index] <= wr_target;
        end
    end

endmodule : branch_target_buffer

`default_nettype wire

/* source/perceptron_predictor.sv */
`default_nettype none
`timescale 1ns/1ps

module perceptron_predictor #(
    parameter int weight_bits      = bp_pkg::default_weight_bits,
    parameter int hist_len         = bp_pkg::default_hist_len,
    parameter int table_index_bits = bp_pkg::default_table_index_bits,
    parameter int btb_index_bits   = bp_pkg::default_btb_index_bits,
    parameter int train_threshold  = bp_pkg::default_train_threshold
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    // fetch stage
    input  wire bp_pkg::word_t          if_pc,
    output logic [weight_bits-1:0]      if_y_out,
    output logic                        if_pred_taken,
    output bp_pkg::word_t               if_pred_target,
    output logic                        btb_hit,

    // resolve stage, ex/mem
    input  wire logic                   load,
    input  wire bp_pkg::word_t          ex_pc,
    input  wire bp_pkg::opcode_t        ex_opcode,
    input  wire logic                   ex_taken,
    input  wire bp_pkg::word_t          ex_target,
    input  wire logic                   ex_pred_taken,
    input  wire logic [weight_bits-1:0] ex_y_out,
    input  wire bp_pkg::word_t          ex_pred_target,
    output logic                        redirect
);

    import bp_pkg::*;

    // fetch row into the evaluator
    logic [weight_bits-1:0] fetch_weights [hist_len+1];

    // resolve row out to the trainer, updated row back
    logic [weight_bits-1:0] old_weights [hist_len+1];
    logic [weight_bits-1:0] new_weights [hist_len+1];

    logic [hist_len-1:0] history;
    logic                table_wr_en;
    logic                btb_wr_en;
    word_t               btb_target;

    perceptron_table #(
        .weight_bits      (weight_bits),
        .hist_len         (hist_len),
        .table_index_bits (table_index_bits)
    ) u_table (
        .clk           (clk),
        .arst_n        (arst_n),
        .rd_pc         (if_pc),
        .rd_weights    (fetch_weights),
        .wr_pc         (ex_pc),
        .wr_en         (table_wr_en),
        .wr_weights    (new_weights),
        .train_weights (old_weights)
    );

    perceptron_eval #(
        .weight_bits (weight_bits),
        .hist_len    (hist_len)
    ) u_eval (
        .weights    (fetch_weights),
        .history    (history),
        .y_out      (if_y_out),
        .pred_taken (if_pred_taken)
    );

    perceptron_trainer #(
        .weight_bits     (weight_bits),
        .hist_len        (hist_len),
        .train_threshold (train_threshold)
    ) u_trainer (
        .clk            (clk),
        .arst_n         (arst_n),
        .load           (load),
        .ex_opcode      (ex_opcode),
        .ex_taken       (ex_taken),
        .ex_target      (ex_target),
        .ex_pred_taken  (ex_pred_taken),
        .ex_y_out       (ex_y_out),
        .ex_pred_target (ex_pred_target),
        .old_weights    (old_weights),
        .history        (history),
        .table_wr_en    (table_wr_en),
        .new_weights    (new_weights),
        .btb_wr_en      (btb_wr_en),
        .redirect       (redirect)
    );

    branch_target_buffer #(
        .btb_index_bits (btb_index_bits)
    ) u_btb (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_pc     (if_pc),
        .hit       (btb_hit),
        .target    (btb_target),
        .wr_pc     (ex_pc),
        .wr_en     (btb_wr_en),
        .wr_target (ex_target)
    );

    // follow the btb only when taken and the entry matches
    // otherwise fall through to the next sequential instruction
    assign if_pred_target = (if_pred_taken && btb_hit) ? btb_target : (if_pc + word_t'(4));

endmodule : perceptron_predictor

`default_nettype wire

/* testbench/predictor_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module predictor_checker (
    input wire logic            clk,
    input wire logic            arst_n,
    input wire bp_pkg::word_t   if_pc,
    input wire logic            if_pred_taken,
    input wire bp_pkg::word_t   if_pred_target,
    input wire logic            btb_hit,
    input wire bp_pkg::opcode_t ex_opcode,
    input wire logic            redirect
);

    import bp_pkg::*;

    // failures seen so far, read by the testbench at the end
    int unsigned fail_total = 0;

    // only branches may flush the front end
    a_redirect_branch_only: assert property (@(posedge clk) disable iff (!arst_n)
        (ex_opcode != op_br) |-> !redirect)
    else begin
        $error("redirect raised for a non-branch opcode");
        fail_total++;
    end

    // btb is empty right after reset
    a_btb_empty_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !btb_hit)
    else begin
        $error("btb hit in the first cycle after reset");
        fail_total++;
    end

    // not taken always falls through
    a_fall_through: assert property (@(posedge clk) disable iff (!arst_n)
        !if_pred_taken |-> (if_pred_target == if_pc + word_t'(4)))
    else begin
        $error("not-taken prediction does not point to pc+4");
        fail_total++;
    end

endmodule : predictor_checker

bind perceptron_predictor predictor_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .if_pc          (if_pc),
    .if_pred_taken  (if_pred_taken),
    .if_pred_target (if_pred_target),
    .btb_hit        (btb_hit),
    .ex_opcode      (ex_opcode),
    .redirect       (redirect)
);

`default_nettype wire

/* testbench/tb_perceptron_predictor.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_perceptron_predictor;

    import bp_pkg::*;

    localparam int wb      = 8;
    localparam int hl      = 12;
    localparam int tib     = 5;
    localparam int bib     = 5;
    localparam int thr     = 37;
    localparam int tag_lsb = 2 + bib;

    // a cleared row under zero history sums hl inverted zeros of -1 each
    localparam logic [wb-1:0] cleared_y = wb'(-hl);

    // test lengths set the timeout budget
    localparam int reset_cycles   = 20;
    localparam int random_cycles  = 600;
    localparam int corrupt_cycles = 200;
    localparam int btb_cycles     = 150;
    localparam int freeze_cycles  = 50;
    localparam int cycle_limit    = reset_cycles + random_cycles + corrupt_cycles
                                  + btb_cycles + freeze_cycles + 100;

    typedef struct packed {
        word_t         pc;
        logic [wb-1:0] y;
        logic          taken;
        word_t         target;
    } fetch_rec_t;

    logic            clk;
    logic            arst_n;
    word_t           if_pc;
    logic [wb-1:0]   if_y_out;
    logic            if_pred_taken;
    word_t           if_pred_target;
    logic            btb_hit;
    logic            load;
    word_t           ex_pc;
    opcode_t         ex_opcode;
    logic            ex_taken;
    word_t           ex_target;
    logic            ex_pred_taken;
    logic [wb-1:0]   ex_y_out;
    word_t           ex_pred_target;
    logic            redirect;

    // reference model state
    logic [wb-1:0]   m_w [2**tib][hl+1];
    logic [hl-1:0]   m_hist;
    logic            m_valid [2**bib];
    logic [31:tag_lsb] m_tag [2**bib];
    word_t           m_target [2**bib];

    fetch_rec_t      pending_q [$];
    logic [wb-1:0]   last_y;
    logic [wb-1:0]   snap_y [16];
    int              pass_count = 0;
    int              fail_count = 0;
    int              cycle_count = 0;
    opcode_t         other_ops [8] = '{op_jal, op_jalr, op_load, op_store,
                                       op_imm, op_reg, op_lui, op_auipc};

    perceptron_predictor #(
        .weight_bits      (wb),
        .hist_len         (hl),
        .table_index_bits (tib),
        .btb_index_bits   (bib),
        .train_threshold  (thr)
    ) uut (
        .clk (clk), .arst_n (arst_n),
        .if_pc (if_pc), .if_y_out (if_y_out), .if_pred_taken (if_pred_taken),
        .if_pred_target (if_pred_target), .btb_hit (btb_hit),
        .load (load), .ex_pc (ex_pc), .ex_opcode (ex_opcode), .ex_taken (ex_taken),
        .ex_target (ex_target), .ex_pred_taken (ex_pred_taken), .ex_y_out (ex_y_out),
        .ex_pred_target (ex_pred_target), .redirect (redirect)
    );

    always #50 clk = ~clk;

    // hard stop if the run overstays its cycle budget
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_weight(input string name, input logic [wb-1:0] exp,
                                  input logic [wb-1:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // 8 btb rows with two tags each so pc k and k+8 collide
    function automatic word_t pool_pc(input int k);
        return 32'h0000_1000 + word_t'((k % 8) * 4) + word_t'((k / 8) * 128);
    endfunction

    // dot product where a 0 history bit takes the inverted weight
    function automatic logic [wb-1:0] model_y(input word_t pc);
        int            idx;
        logic [wb-1:0] sum;
        idx = int'(pc[2 +: tib]);
        sum = m_w[idx][hl];
        for (int i = 0; i < hl; i++) begin
            sum = sum + (m_hist[i] ? m_w[idx][i] : ~m_w[idx][i]);
        end
        return sum;
    endfunction

    function automatic logic model_hit(input word_t pc);
        int idx;
        idx = int'(pc[2 +: bib]);
        return m_valid[idx] && (m_tag[idx] == pc[31:tag_lsb]);
    endfunction

    // model state step for the coming rising edge
    task automatic model_update();
        int   idx;
        int   bidx;
        int   mag;
        logic train;
        idx  = int'(ex_pc[2 +: tib]);
        bidx = int'(ex_pc[2 +: bib]);
        mag  = int'($signed(ex_y_out));
        if (mag < 0) begin
            mag = -mag;
        end
        train = (ex_pred_taken != ex_taken) || (mag < thr);
        if (load && ex_opcode == op_br) begin
            if (train) begin
                for (int i = 0; i < hl; i++) begin
                    m_w[idx][i] = m_w[idx][i] + ((ex_taken == m_hist[i]) ? wb'(1) : {wb{1'b1}});
                end
                m_w[idx][hl] = m_w[idx][hl] + (ex_taken ? wb'(1) : {wb{1'b1}});
            end
            m_valid[bidx]  = 1'b1;
            m_tag[bidx]    = ex_pc[31:tag_lsb];
            m_target[bidx] = ex_target;
            m_hist = {m_hist[hl-2:0], ex_taken};
        end
    endtask

    // one clock with drive at the falling edge and checks before the rising edge
    task automatic run_cycle(input word_t pc, input int load_pct, input int corrupt_pct,
                             input bit reset_mode);
        fetch_rec_t    prev;
        fetch_rec_t    cur;
        logic [wb-1:0] exp_y;
        logic          exp_taken;
        logic          exp_hit;
        word_t         exp_target;
        logic          exp_redirect;
        @(negedge clk);
        prev           = pending_q.pop_front();
        if_pc          = pc;
        ex_pc          = prev.pc;
        ex_y_out       = prev.y;
        ex_pred_taken  = prev.taken;
        ex_pred_target = prev.target;
        ex_opcode      = ($urandom_range(0, 99) < 70) ? op_br : other_ops[$urandom_range(0, 7)];
        ex_taken       = 1'($urandom_range(0, 1));
        // half the targets repeat per pc so the btb can be right
        ex_target      = ($urandom_range(0, 1) == 1) ? prev.pc + 32'h40 : ($urandom & ~32'h3);
        load           = ($urandom_range(0, 99) < load_pct);
        if ($urandom_range(0, 99) < corrupt_pct) begin
            ex_pred_taken = ~ex_pred_taken;
        end
        if ($urandom_range(0, 99) < corrupt_pct) begin
            ex_pred_target = ex_pred_target + 32'h10;
        end
        #10;
        exp_y        = model_y(pc);
        exp_taken    = ($signed(exp_y) > 0);
        exp_hit      = model_hit(pc);
        exp_target   = (exp_taken && exp_hit) ? m_target[int'(pc[2 +: bib])] : pc + 32'd4;
        exp_redirect = (ex_opcode == op_br) && ((ex_pred_taken != ex_taken)
                       || (ex_taken && ex_pred_target != ex_target));
        compare_weight("if_y_out", exp_y, if_y_out);
        compare_bit("if_pred_taken", exp_taken, if_pred_taken);
        compare_bit("btb_hit", exp_hit, btb_hit);
        compare_word("if_pred_target", exp_target, if_pred_target);
        compare_bit("redirect", exp_redirect, redirect);
        if (reset_mode) begin
            compare_weight("if_y_out", cleared_y, if_y_out);
            compare_bit("if_pred_taken", 1'b0, if_pred_taken);
            compare_bit("btb_hit", 1'b0, btb_hit);
            compare_word("if_pred_target", pc + 32'd4, if_pred_target);
        end
        last_y = if_y_out;
        cur = '{pc: pc, y: if_y_out, taken: if_pred_taken, target: if_pred_target};
        pending_q.push_back(cur);
        model_update();
    endtask

    // mode 0 reset, 1 random, 2 heavy corruption, 3 btb conflicts, 4 freeze
    task automatic run_test(input string name, input int cycles, input int mode);
        int    fails_before;
        word_t pc;
        fails_before = fail_count;
        for (int c = 0; c < cycles; c++) begin
            case (mode)
                3:       pc = pool_pc(($urandom_range(0, 1) * 8) + int'($urandom_range(0, 1)));
                4:       pc = pool_pc(c % 16);
                default: pc = pool_pc(int'($urandom_range(0, 15)));
            endcase
            run_cycle(pc, (mode == 0 || mode == 4) ? 0 : 85, (mode == 2) ? 40 : 10, mode == 0);
            // frozen state must repeat the first pass exactly
            if (mode == 4) begin
                if (c < 16) begin
                    snap_y[c] = last_y;
                end else begin
                    compare_weight("if_y_out (frozen)", snap_y[c % 16], last_y);
                end
            end
        end
        $display("test %s: %0d cycles, %0d mismatches", name, cycles, fail_count - fails_before);
    endtask

    initial begin
        void'($urandom(32'heacf7b06));
        clk = 1'b0;
        arst_n = 1'b0;
        if_pc = '0;
        load = 1'b0;
        ex_pc = '0;
        ex_opcode = op_imm;
        ex_taken = 1'b0;
        ex_target = '0;
        ex_pred_taken = 1'b0;
        ex_y_out = '0;
        ex_pred_target = '0;
        // model starts cleared as after reset
        for (int r = 0; r < 2**tib; r++) begin
            for (int j = 0; j <= hl; j++) begin
                m_w[r][j] = '0;
            end
        end
        for (int e = 0; e < 2**bib; e++) begin
            m_valid[e]  = 1'b0;
            m_tag[e]    = '0;
            m_target[e] = '0;
        end
        m_hist = '0;
        pending_q.push_back('{pc: pool_pc(0), y: '0, taken: 1'b0, target: pool_pc(0) + 32'd4});
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_test("reset_state", reset_cycles, 0);
        run_test("random_train", random_cycles, 1);
        run_test("redirect_corrupt", corrupt_cycles, 2);
        run_test("btb_conflict", btb_cycles, 3);
        run_test("freeze", freeze_cycles, 4);

        // assertion failures from the bound checker count as well
        fail_count += int'(uut.u_checker.fail_total);
        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_perceptron_predictor

`default_nettype wire

/* src.f */
source/bp_pkg.sv
source/perceptron_table.sv
source/perceptron_eval.sv
source/perceptron_trainer.sv
source/branch_target_buffer.sv
source/perceptron_predictor.sv
testbench/predictor_checker.sv
testbench/tb_perceptron_predictor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_perceptron_predictor -f src.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
